/* Makefile */
VERILATOR ?= verilator
TOP ?= csrUnitTb
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
logic/csrPkg.sv
logic/interruptSelect.sv
logic/csrCounters.sv
logic/csrTrapState.sv
logic/csrExecute.sv
logic/csrUnit.sv
verification/csrUnitTb.sv

/* logic/csrCounters.sv */
`timescale 1ns/1ps
`default_nettype none

module csrCounters (
    input wire logic clk,
    input wire logic rst,
    input wire logic [csrPkg::csrAddrWidth-1:0] csrAddr,
    input csrPkg::privLevel_t priv,
    input wire logic writeEn,
    input wire logic [csrPkg::csrAddrWidth-1:0] writeAddr,
    input wire logic [csrPkg::xlen-1:0] writeData,
    input wire logic [csrPkg::commitWidth-1:0] commitValid,
    output logic [csrPkg::xlen-1:0] readData,
    output logic readHit
);
    import csrPkg::*;

    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic cycleInhibit, instretInhibit; // mcountinhibit bits 0 and 2
    logic cycleEn, instretEn;           // mcounteren bits 0 and 2
    logic [$clog2(commitWidth+1)-1:0] retired;

    always_comb begin
        retired = '0;
        for (int i = 0; i < commitWidth; i++)
            retired = retired + commitValid[i];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            cycleInhibit <= 1'b0;
            instretInhibit <= 1'b0;
            cycleEn <= 1'b0;
            instretEn <= 1'b0;
        end else begin
            if (!cycleInhibit)
                mcycle <= mcycle + 64'd1;
            if (!instretInhibit)
                minstret <= minstret + retired;

            // later assignment overrides the increment
            if (writeEn) begin
                case (writeAddr)
                    csrMcycle: mcycle[31:0] <= writeData;
                    csrMcycleh: mcycle[63:32] <= writeData;
                    csrMinstret: minstret[31:0] <= writeData;
                    csrMinstreth: minstret[63:32] <= writeData;
                    csrMcountinhibit: begin
                        cycleInhibit <= writeData[0];
                        instretInhibit <= writeData[2];
                    end
                    csrMcounteren: begin
                        cycleEn <= writeData[0];
                        instretEn <= writeData[2];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        readHit = 1'b1;
        case (csrAddr)
            csrMcycle: readData = mcycle[31:0];
            csrMcycleh: readData = mcycle[63:32];
            csrMinstret: readData = minstret[31:0];
            csrMinstreth: readData = minstret[63:32];
            csrMcountinhibit: readData = {{(xlen-3){1'b0}}, instretInhibit, 1'b0, cycleInhibit};
            csrMcounteren: readData = {{(xlen-3){1'b0}}, instretEn, 1'b0, cycleEn};
            csrCycle, csrCycleh: begin
                readData = (csrAddr == csrCycle) ? mcycle[31:0] : mcycle[63:32];
                readHit = (priv == privMachine) || cycleEn;
            end
            csrInstret, csrInstreth: begin
                readData = (csrAddr == csrInstret) ? minstret[31:0] : minstret[63:32];
                readHit = (priv == privMachine) || instretEn;
            end
            default: begin
                readData = '0;
                readHit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/csrExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module csrExecute (
    input wire logic clk,
    input wire logic rst,
    input wire logic opValid,
    input csrPkg::csrOp_t op,
    input wire logic [csrPkg::csrAddrWidth-1:0] csrAddr,
    input wire logic [csrPkg::xlen-1:0] srcA,
    input wire logic [4:0] zimm,
    input csrPkg::privLevel_t priv,
    input wire logic [1:0][csrPkg::xlen-1:0] readData,
    input wire logic [1:0] readHit,
    output logic writeEn,
    output logic [csrPkg::csrAddrWidth-1:0] writeAddr,
    output logic [csrPkg::xlen-1:0] writeData,
    output logic mretEn,
    output logic resultValid,
    output logic [csrPkg::xlen-1:0] result,
    output csrPkg::resultFlags_t resultFlags
);
    import csrPkg::*;

    logic [xlen-1:0] readWord;
    logic [xlen-1:0] operand;
    logic isMret;
    logic isWrite;
    logic illegal;

    always_comb begin
        readWord = (readHit[0] ? readData[0] : '0) | (readHit[1] ? readData[1] : '0);
        operand = (op inside {opRwi, opRsi, opRci}) ? {{(xlen-5){1'b0}}, zimm} : srcA;
        isMret = (op == opMret);
        isWrite = (op != opRead) && !isMret;

        if (isMret)
            illegal = (priv != privMachine);
        else
            illegal = (readHit == 2'b00)                      // unknown or not permitted
                || (csrAddr[9:8] > priv)                      // privilege field
                || (isWrite && csrAddr[11:10] == 2'b11);      // read-only space

        case (op)
            opRs, opRsi: writeData = readWord | operand;
            opRc, opRci: writeData = readWord & ~operand;
            default: writeData = operand;
        endcase
    end

    // state updates land on the same edge as the result register
    assign writeEn = opValid && isWrite && !illegal;
    assign writeAddr = csrAddr;
    assign mretEn = opValid && isMret && !illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            resultFlags <= flagsNone;
        end else begin
            resultValid <= opValid;
            if (opValid) begin
                if (illegal)
                    resultFlags <= flagsIllegal;
                else if (isMret)
                    resultFlags <= flagsXret;
                else if (isWrite)
                    resultFlags <= flagsOrdering;
                else
                    resultFlags <= flagsNone;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (opValid)
            result <= (illegal || isMret) ? '0 : readWord; // old value
    end

endmodule

`default_nettype wire

/* logic/csrPkg.sv */
`default_nettype none

package csrPkg;

    localparam int xlen = 32;
    localparam int csrAddrWidth = 12;
    localparam int causeWidth = 4;
    localparam int commitWidth = 4;

    // interrupt bit positions in mie/mip
    localparam int irqMsi = 3;
    localparam int irqMti = 7;
    localparam int irqMei = 11;

    localparam logic [xlen-1:0] archId = 32'h0000_0c51;
    localparam logic [xlen-1:0] impId = 32'h0000_0001;

    typedef enum logic [csrAddrWidth-1:0] {
        csrMstatus = 12'h300,
        csrMie = 12'h304,
        csrMtvec = 12'h305,
        csrMcounteren = 12'h306,
        csrMcountinhibit = 12'h320,
        csrMscratch = 12'h340,
        csrMepc = 12'h341,
        csrMcause = 12'h342,
        csrMtval = 12'h343,
        csrMip = 12'h344,
        csrMcycle = 12'hb00,
        csrMinstret = 12'hb02,
        csrMcycleh = 12'hb80,
        csrMinstreth = 12'hb82,
        csrCycle = 12'hc00,
        csrInstret = 12'hc02,
        csrCycleh = 12'hc80,
        csrInstreth = 12'hc82,
        csrMvendorid = 12'hf11,
        csrMarchid = 12'hf12,
        csrMimpid = 12'hf13,
        csrMhartid = 12'hf14
    } csrAddr_t;

    typedef enum logic [1:0] {
        privUser = 2'd0,
        privMachine = 2'd3
    } privLevel_t;

    typedef enum logic [2:0] {
        opRead, opRw, opRs, opRc, opRwi, opRsi, opRci, opMret
    } csrOp_t;

    typedef enum logic [1:0] {
        flagsNone, flagsOrdering, flagsIllegal, flagsXret
    } resultFlags_t;

    // only mie, mpie and mpp are implemented, rest reads zero
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [18:0] zero13;
            privLevel_t mpp;
            logic [2:0] zero8;
            logic mpie;
            logic [2:0] zero4;
            logic mie;
            logic [2:0] zero0;
        } fields;
    } mstatusWord_t;

endpackage

`default_nettype wire

/* logic/csrTrapState.sv */
`timescale 1ns/1ps
`default_nettype none

module csrTrapState (
    input wire logic clk,
    input wire logic rst,
    input wire logic [csrPkg::csrAddrWidth-1:0] csrAddr,
    input wire logic writeEn,
    input wire logic [csrPkg::csrAddrWidth-1:0] writeAddr,
    input wire logic [csrPkg::xlen-1:0] writeData,
    input wire logic mretEn,
    input wire logic trapValid,
    input wire logic [csrPkg::xlen-1:0] trapPc,
    input wire logic [csrPkg::causeWidth-1:0] trapCause,
    input wire logic trapIsInterrupt,
    input wire logic extIrq,
    input wire logic timerIrq,
    output logic [csrPkg::xlen-1:0] readData,
    output logic readHit,
    output csrPkg::privLevel_t priv,
    output logic mstatusMie,
    output logic [csrPkg::xlen-1:0] mieBits,
    output logic [csrPkg::xlen-1:0] mipBits,
    output logic [csrPkg::xlen-1:0] mtvecBase,
    output logic [csrPkg::xlen-1:0] retVec
);
    import csrPkg::*;

    mstatusWord_t mstatus;
    mstatusWord_t writeStatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [causeWidth-1:0] mcauseCode;
    logic mcauseInt;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] mie;
    logic msip, mtip, meip;

    assign writeStatus.raw = writeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= privMachine;
            mstatus.raw <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcauseCode <= '0;
            mcauseInt <= 1'b0;
            mtval <= '0;
            mie <= '0;
            msip <= 1'b0;
            mtip <= 1'b0;
            meip <= 1'b0;
            retVec <= '0;
        end else begin
            mtip <= timerIrq;
            meip <= extIrq;

            if (trapValid) begin // wins over a coinciding write
                mepc <= {trapPc[xlen-1:1], 1'b0};
                mcauseCode <= trapCause;
                mcauseInt <= trapIsInterrupt;
                mstatus.fields.mpie <= mstatus.fields.mie;
                mstatus.fields.mie <= 1'b0;
                mstatus.fields.mpp <= priv;
                mtval <= '0;
                priv <= privMachine;
            end else if (mretEn) begin
                mstatus.fields.mie <= mstatus.fields.mpie;
                mstatus.fields.mpp <= privUser;
                priv <= mstatus.fields.mpp;
                retVec <= mepc;
            end else if (writeEn) begin
                case (writeAddr)
                    csrMstatus: begin
                        mstatus.fields.mie <= writeStatus.fields.mie;
                        mstatus.fields.mpie <= writeStatus.fields.mpie;
                        // only user and machine exist
                        mstatus.fields.mpp <= (writeStatus.fields.mpp == privMachine)
                            ? privMachine : privUser;
                    end
                    csrMie: begin
                        mie[irqMsi] <= writeData[irqMsi];
                        mie[irqMti] <= writeData[irqMti];
                        mie[irqMei] <= writeData[irqMei];
                    end
                    csrMtvec: mtvec <= {writeData[xlen-1:2], 2'b00}; // direct mode only
                    csrMscratch: mscratch <= writeData;
                    csrMepc: mepc <= {writeData[xlen-1:1], 1'b0};
                    csrMcause: begin
                        mcauseCode <= writeData[causeWidth-1:0];
                        mcauseInt <= writeData[xlen-1];
                    end
                    csrMtval: mtval <= writeData;
                    csrMip: msip <= writeData[irqMsi];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        mipBits = '0;
        mipBits[irqMsi] = msip;
        mipBits[irqMti] = mtip;
        mipBits[irqMei] = meip;
    end

    assign mieBits = mie;
    assign mstatusMie = mstatus.fields.mie;
    assign mtvecBase = mtvec;

    always_comb begin
        readHit = 1'b1;
        case (csrAddr)
            csrMstatus: readData = mstatus.raw;
            csrMie: readData = mie;
            csrMtvec: readData = mtvec;
            csrMscratch: readData = mscratch;
            csrMepc: readData = mepc;
            csrMcause: readData = {mcauseInt, {(xlen-1-causeWidth){1'b0}}, mcauseCode};
            csrMtval: readData = mtval;
            csrMip: readData = mipBits;
            csrMarchid: readData = archId;
            csrMimpid: readData = impId;
            csrMvendorid, csrMhartid: readData = '0;
            default: begin
                readData = '0;
                readHit = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/csrUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module csrUnit (
    input wire logic clk,
    input wire logic rst,
    input wire logic opValid,
    input csrPkg::csrOp_t op,
    input wire logic [csrPkg::csrAddrWidth-1:0] csrAddr,
    input wire logic [csrPkg::xlen-1:0] srcA,
    input wire logic [4:0] zimm,
    input wire logic trapValid,
    input wire logic [csrPkg::xlen-1:0] trapPc,
    input wire logic [csrPkg::causeWidth-1:0] trapCause,
    input wire logic trapIsInterrupt,
    input wire logic [csrPkg::commitWidth-1:0] commitValid,
    input wire logic extIrq,
    input wire logic timerIrq,
    output logic resultValid,
    output logic [csrPkg::xlen-1:0] result,
    output csrPkg::resultFlags_t resultFlags,
    output csrPkg::privLevel_t priv,
    output logic [csrPkg::xlen-1:0] mtvecBase,
    output logic [csrPkg::xlen-1:0] retVec,
    output logic interruptPending,
    output logic [csrPkg::causeWidth-1:0] interruptCause
);
    import csrPkg::*;

    logic [1:0][xlen-1:0] readData; // 0 trap state, 1 counters
    logic [1:0] readHit;
    logic writeEn;
    logic [csrAddrWidth-1:0] writeAddr;
    logic [xlen-1:0] writeData;
    logic mretEn;
    logic mstatusMie;
    logic [xlen-1:0] mieBits;
    logic [xlen-1:0] mipBits;

    csrExecute csrExecute_i (
        .clk(clk), .rst(rst),
        .opValid(opValid), .op(op), .csrAddr(csrAddr), .srcA(srcA), .zimm(zimm),
        .priv(priv), .readData(readData), .readHit(readHit),
        .writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
        .mretEn(mretEn),
        .resultValid(resultValid), .result(result), .resultFlags(resultFlags)
    );

    csrTrapState csrTrapState_i (
        .clk(clk), .rst(rst), .csrAddr(csrAddr),
        .writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
        .mretEn(mretEn),
        .trapValid(trapValid), .trapPc(trapPc), .trapCause(trapCause),
        .trapIsInterrupt(trapIsInterrupt),
        .extIrq(extIrq), .timerIrq(timerIrq),
        .readData(readData[0]), .readHit(readHit[0]),
        .priv(priv), .mstatusMie(mstatusMie), .mieBits(mieBits), .mipBits(mipBits),
        .mtvecBase(mtvecBase), .retVec(retVec)
    );

    csrCounters csrCounters_i (
        .clk(clk), .rst(rst), .csrAddr(csrAddr), .priv(priv),
        .writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
        .commitValid(commitValid),
        .readData(readData[1]), .readHit(readHit[1])
    );

    interruptSelect interruptSelect_i (
        .priv(priv), .mstatusMie(mstatusMie), .mieBits(mieBits), .mipBits(mipBits),
        .interruptPending(interruptPending), .interruptCause(interruptCause)
    );

endmodule

`default_nettype wire

/* logic/interruptSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module interruptSelect (
    input csrPkg::privLevel_t priv,
    input wire logic mstatusMie,
    input wire logic [csrPkg::xlen-1:0] mieBits,
    input wire logic [csrPkg::xlen-1:0] mipBits,
    output logic interruptPending,
    output logic [csrPkg::causeWidth-1:0] interruptCause
);
    import csrPkg::*;

    logic globalEn;
    logic [xlen-1:0] active;

    assign globalEn = (priv == privUser) || mstatusMie;
    assign active = mipBits & mieBits;

    always_comb begin
        interruptPending = 1'b0;
        interruptCause = '0;
        if (globalEn) begin
            // external > software > timer
            if (active[irqMei]) begin
                interruptPending = 1'b1;
                interruptCause = causeWidth'(irqMei);
            end else if (active[irqMsi]) begin
                interruptPending = 1'b1;
                interruptCause = causeWidth'(irqMsi);
            end else if (active[irqMti]) begin
                interruptPending = 1'b1;
                interruptCause = causeWidth'(irqMti);
            end
        end
    end

endmodule

`default_nettype wire

/* verification/csrTrace.txt */
# test opValid op addr srcA zimm | trapValid trapPc cause isInt | commit ext timer
# mask(1 result 2 flags 4 irq 8 priv 10 retVec) | result flags pending cause priv retVec
1 1 1 340 a5a50f0f 0 0 0 0 0 0 0 0 3 00000000 1 0 0 0 0
1 1 2 340 00f00000 0 0 0 0 0 0 0 0 3 a5a50f0f 1 0 0 0 0
1 1 3 340 0000000f 0 0 0 0 0 0 0 0 3 a5f50f0f 1 0 0 0 0
1 1 5 340 0 03 0 0 0 0 0 0 0 3 a5f50f00 1 0 0 0 0
1 1 6 340 0 01 0 0 0 0 0 0 0 3 a5f50f03 1 0 0 0 0
1 1 4 340 0 1f 0 0 0 0 0 0 0 3 a5f50f02 1 0 0 0 0
1 1 0 340 0 0 0 0 0 0 0 0 0 3 0000001f 0 0 0 0 0
2 1 0 7c0 0 0 0 0 0 0 0 0 0 3 0 2 0 0 0 0
2 1 1 f12 1 0 0 0 0 0 0 0 0 3 0 2 0 0 0 0
2 1 7 000 0 0 0 0 0 0 0 0 0 1b 0 3 0 0 0 0
2 1 7 000 0 0 0 0 0 0 0 0 0 b 0 2 0 0 0 0
2 1 0 340 0 0 0 0 0 0 0 0 0 3 0 2 0 0 0 0
2 1 0 c00 0 0 0 0 0 0 0 0 0 3 0 2 0 0 0 0
2 0 0 000 0 0 1 00001000 2 0 0 0 0 8 0 0 0 0 3 0
2 1 4 306 0 01 0 0 0 0 0 0 0 3 0 1 0 0 0 0
2 1 7 000 0 0 0 0 0 0 0 0 0 1b 0 3 0 0 0 00001000
2 1 0 c00 0 0 0 0 0 0 0 0 0 a 0 0 0 0 0 0
3 0 0 000 0 0 1 00002000 2 0 0 0 0 8 0 0 0 0 3 0
3 1 5 300 0 08 0 0 0 0 0 0 0 3 0 1 0 0 0 0
3 0 0 000 0 0 1 00002344 7 1 0 0 0 8 0 0 0 0 3 0
3 1 0 341 0 0 0 0 0 0 0 0 0 3 00002344 0 0 0 0 0
3 1 0 342 0 0 0 0 0 0 0 0 0 3 80000007 0 0 0 0 0
3 1 0 300 0 0 0 0 0 0 0 0 0 3 00001880 0 0 0 0 0
3 1 7 000 0 0 0 0 0 0 0 0 0 1b 0 3 0 0 3 00002344
3 1 0 300 0 0 0 0 0 0 0 0 0 3 00000088 0 0 0 0 0
4 1 1 304 00000888 0 0 0 0 0 0 0 0 7 0 1 0 0 0 0
4 0 0 000 0 0 0 0 0 0 0 0 1 4 0 0 1 7 0 0
4 0 0 000 0 0 0 0 0 0 0 1 1 4 0 0 1 b 0 0
4 1 5 344 0 08 0 0 0 0 0 1 1 7 00000880 1 1 b 0 0
4 1 6 300 0 08 0 0 0 0 0 1 1 7 00000088 1 0 0 0 0
5 1 4 320 0 05 0 0 0 0 0 0 0 3 0 1 0 0 0 0
5 1 1 b02 00000100 0 0 0 0 0 0 0 0 3 0 1 0 0 0 0
5 0 0 000 0 0 0 0 0 0 f 0 0 0 0 0 0 0 0 0
5 0 0 000 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0
5 1 0 b02 0 0 0 0 0 0 f 0 0 3 00000100 0 0 0 0 0
5 1 6 320 0 05 0 0 0 0 0 0 0 3 00000005 1 0 0 0 0
5 0 0 000 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
5 0 0 000 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0
5 0 0 000 0 0 0 0 0 0 f 0 0 0 0 0 0 0 0 0
5 0 0 000 0 0 0 0 0 0 a 0 0 0 0 0 0 0 0 0
5 1 0 b02 0 0 0 0 0 0 0 0 0 3 0000010a 0 0 0 0 0
5 1 0 b82 0 0 0 0 0 0 0 0 0 3 0 0 0 0 0 0

/* verification/csrUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb;
    import csrPkg::*;

    localparam string tracePath = "verification/csrTrace.txt";
    localparam int stepTimeout = 1; // result is due one cycle after the op

    logic clk;
    logic rst;
    logic opValid;
    csrOp_t op;
    logic [csrAddrWidth-1:0] csrAddr;
    logic [xlen-1:0] srcA;
    logic [4:0] zimm;
    logic trapValid;
    logic [xlen-1:0] trapPc;
    logic [causeWidth-1:0] trapCause;
    logic trapIsInterrupt;
    logic [commitWidth-1:0] commitValid;
    logic extIrq;
    logic timerIrq;
    logic resultValid;
    logic [xlen-1:0] result;
    resultFlags_t resultFlags;
    privLevel_t priv;
    logic [xlen-1:0] mtvecBase;
    logic [xlen-1:0] retVec;
    logic interruptPending;
    logic [causeWidth-1:0] interruptCause;

    int fd;
    int fieldCount;
    int testNum;
    int curTest;
    int tests;
    int steps;
    int errors;
    int testErrors;
    logic timedOut;
    string line;
    // one trace line, see the header of the trace file
    logic [31:0] fValid, fOp, fAddr, fSrc, fZimm, fTrap, fPc, fCause, fInt;
    logic [31:0] fCommit, fExt, fTmr, fMask;
    logic [31:0] eRes, eFlags, ePend, eCause, ePriv, eRet;
    logic [xlen-1:0] expMtvec; // zero after reset

    csrUnit csrUnit_i (
        .clk(clk), .rst(rst),
        .opValid(opValid), .op(op), .csrAddr(csrAddr), .srcA(srcA), .zimm(zimm),
        .trapValid(trapValid), .trapPc(trapPc), .trapCause(trapCause),
        .trapIsInterrupt(trapIsInterrupt), .commitValid(commitValid),
        .extIrq(extIrq), .timerIrq(timerIrq),
        .resultValid(resultValid), .result(result), .resultFlags(resultFlags),
        .priv(priv), .mtvecBase(mtvecBase), .retVec(retVec),
        .interruptPending(interruptPending), .interruptCause(interruptCause)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            testErrors++;
        end
    endtask

    // one edge per step, an op must have its result by then
    task automatic waitStep(input logic needResult);
        int cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done && !timedOut) begin
            @(posedge clk);
            #2;
            opValid = 1'b0; // strobes last one cycle
            trapValid = 1'b0;
            cycles++;
            if (!needResult || resultValid)
                done = 1'b1;
            else if (cycles >= stepTimeout) begin
                $display("timeout: resultValid did not rise within %0d cycles at %0t",
                    stepTimeout, $time);
                timedOut = 1'b1;
            end
        end
    endtask

    // mtvec base as the legal writes of the trace leave it
    task automatic trackMtvec();
        csrOp_t stepOp;
        logic [xlen-1:0] operand;
        stepOp = csrOp_t'(fOp[2:0]);
        operand = (stepOp inside {opRwi, opRsi, opRci}) ? {27'b0, fZimm[4:0]} : fSrc;
        // a trap in the same step wins over the write
        if (fValid[0] && !fTrap[0] && fAddr[csrAddrWidth-1:0] == csrMtvec
                && eFlags[1:0] == flagsOrdering) begin
            case (stepOp)
                opRw, opRwi: expMtvec = operand;
                opRs, opRsi: expMtvec = expMtvec | operand;
                opRc, opRci: expMtvec = expMtvec & ~operand;
                default: ;
            endcase
            expMtvec[1:0] = 2'b00; // base is word aligned
        end
    endtask

    task automatic reportTest(input int num);
        if (testErrors == 0)
            $display("test %0d passed", num);
        else
            $display("test %0d failed with %0d mismatches", num, testErrors);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        opValid = 1'b0;
        op = opRead;
        csrAddr = '0;
        srcA = '0;
        zimm = '0;
        trapValid = 1'b0;
        trapPc = '0;
        trapCause = '0;
        trapIsInterrupt = 1'b0;
        commitValid = '0;
        extIrq = 1'b0;
        timerIrq = 1'b0;
        curTest = 0;
        tests = 0;
        steps = 0;
        errors = 0;
        testErrors = 0;
        timedOut = 1'b0;
        expMtvec = '0;

        fd = $fopen(tracePath, "r");
        if (fd == 0)
            $display("could not open the trace file %s", tracePath);

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        while (fd != 0 && !timedOut && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            fieldCount = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                testNum, fValid, fOp, fAddr, fSrc, fZimm, fTrap, fPc, fCause, fInt,
                fCommit, fExt, fTmr, fMask, eRes, eFlags, ePend, eCause, ePriv, eRet);
            if (fieldCount != 20) begin
                $display("malformed trace line: %s", line);
                errors++;
                continue;
            end
            if (testNum != curTest) begin
                if (curTest != 0)
                    reportTest(curTest);
                curTest = testNum;
                testErrors = 0;
                tests++;
            end

            opValid = fValid[0];
            op = csrOp_t'(fOp[2:0]);
            csrAddr = fAddr[csrAddrWidth-1:0];
            srcA = fSrc;
            zimm = fZimm[4:0];
            trapValid = fTrap[0];
            trapPc = fPc;
            trapCause = fCause[causeWidth-1:0];
            trapIsInterrupt = fInt[0];
            commitValid = fCommit[commitWidth-1:0];
            extIrq = fExt[0];
            timerIrq = fTmr[0];

            waitStep(fValid[0]);
            if (!timedOut) begin
                if (!fValid[0])
                    checkValue("resultValid", 32'd0, 32'(resultValid));
                trackMtvec();
                checkValue("mtvecBase", expMtvec, mtvecBase);
                if (fMask[0])
                    checkValue("result", eRes, result);
                if (fMask[1])
                    checkValue("resultFlags", eFlags, 32'(resultFlags));
                if (fMask[2]) begin
                    checkValue("interruptPending", ePend, 32'(interruptPending));
                    checkValue("interruptCause", eCause, 32'(interruptCause));
                end
                if (fMask[3])
                    checkValue("priv", ePriv, 32'(priv));
                if (fMask[4])
                    checkValue("retVec", eRet, retVec);
            end
            steps++;
        end

        if (curTest != 0 && !timedOut)
            reportTest(curTest);
        if (fd != 0)
            $fclose(fd);
        $display("%0d tests, %0d steps, %0d errors", tests, steps, errors);
        if (fd == 0 || timedOut || steps == 0 || errors != 0)
            $display("Test failed");
        else
            $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
